//--- src/loader_pkg.sv
////////////////////////////////////////////////////////////
// Shared widths, types and constants for the NES image loader
// Mapper flags word, memory write command, load FSM states
////////////////////////////////////////////////////////////

package loader_pkg;

	// Widths that carry a meaning
	typedef logic [7:0]  byte_t;        // File or memory data byte
	typedef logic [21:0] mem_addr_t;    // Cartridge memory byte address
	typedef logic [21:0] byte_count_t;  // Bytes left in a section
	typedef logic [2:0]  size_code_t;   // log2 size code, PRG or CHR

	////////////////////////////////////////////////////////////
	// iNES layout constants
	////////////////////////////////////////////////////////////

	localparam int HEADER_BYTES   = 16;
	localparam int PRG_PAGE_SHIFT = 14;  // 16 KiB pages
	localparam int CHR_PAGE_SHIFT = 13;  // 8 KiB pages

	localparam mem_addr_t PRG_BASE = 22'h000000;
	localparam mem_addr_t CHR_BASE = 22'h200000;  // CHR region

	localparam logic [31:0] INES_MAGIC         = 32'h4E45_531A;  // "NES" then 1Ah
	localparam logic [5:0]  PIANO_EXPANSION_ID = 6'h19;

	////////////////////////////////////////////////////////////
	// Structured types
	////////////////////////////////////////////////////////////

	// Flags word handed to the NES core, top bit first
	typedef struct packed {
		logic       reserved;
		logic       piano;           // Miracle Piano expansion
		logic [3:0] prg_ram_shift;   // PRG RAM is 64 << shift
		logic       has_saves;       // Battery backed RAM
		byte_t      submapper_byte;  // Header byte 8, NES 2.0 only
		logic       four_screen;
		logic       chr_ram;         // No CHR ROM pages
		logic       mirroring;
		size_code_t chr_size;
		size_code_t prg_size;
		byte_t      mapper;
	} mapper_flags_t;

	// One pending memory write
	typedef struct packed {
		mem_addr_t addr;
		byte_t     data;
	} mem_write_t;

	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		LOAD_DONE,
		LOAD_ERROR
	} load_state_t;

endpackage

//--- src/ines_header_decode.sv
////////////////////////////////////////////////////////////
// iNES / NES 2.0 header store and decode
// Signature check, section sizes and the mapper flags word
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ines_header_decode (
	input  logic                      clk,
	input  logic                      reset_nes,
	input  logic                      header_wr,
	input  loader_pkg::byte_t         header_byte,
	input  logic                      invert_mirroring,
	output logic                      header_ok,
	output loader_pkg::byte_count_t   prg_bytes,
	output loader_pkg::byte_count_t   chr_bytes,
	output loader_pkg::mapper_flags_t mapper_flags
);
	import loader_pkg::*;

	byte_t      ines [HEADER_BYTES];  // Raw header bytes
	logic [3:0] wr_index;
	logic       header_full;          // All 16 bytes captured
	logic       is_nes20;
	logic       is_dirty;

	// Smallest power of two at or above the page count
	function automatic size_code_t size_code(input byte_t pages);
		size_code_t code;
		if (pages <= 8'd1)
			code = 3'd0;
		else if (pages <= 8'd2)
			code = 3'd1;
		else if (pages <= 8'd4)
			code = 3'd2;
		else if (pages <= 8'd8)
			code = 3'd3;
		else if (pages <= 8'd16)
			code = 3'd4;
		else if (pages <= 8'd32)
			code = 3'd5;
		else if (pages <= 8'd64)
			code = 3'd6;
		else
			code = 3'd7;
		return code;
	endfunction

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			wr_index    <= '0;
			header_full <= 1'b0;
		end else if (header_wr && !header_full) begin
			wr_index <= wr_index + 4'd1;
			if (wr_index == 4'd15)
				header_full <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (header_wr && !header_full)
			ines[wr_index] <= header_byte;
	end

	// Trainers are not supported
	assign header_ok = ({ines[0], ines[1], ines[2], ines[3]} == INES_MAGIC) && !ines[6][2];

	assign prg_bytes = byte_count_t'(ines[4]) << PRG_PAGE_SHIFT;
	assign chr_bytes = byte_count_t'(ines[5]) << CHR_PAGE_SHIFT;

	assign is_nes20 = (ines[7][3:2] == 2'b10);
	// Junk in the tail of an old header, typically a ripper tag
	assign is_dirty = !is_nes20 && ((ines[9][7:1] != 7'd0)
		|| (|{ines[10], ines[11], ines[12], ines[13], ines[14], ines[15]}));

	always_comb begin
		mapper_flags                = '0;
		mapper_flags.piano          = is_nes20 && (ines[15][5:0] == PIANO_EXPANSION_ID);
		mapper_flags.prg_ram_shift  = is_nes20 ? ines[10][3:0] : 4'd0;
		mapper_flags.has_saves      = ines[6][1];
		mapper_flags.submapper_byte = is_nes20 ? ines[8] : 8'h00;
		mapper_flags.four_screen    = ines[6][3];
		mapper_flags.chr_ram        = (ines[5] == 8'd0);
		mapper_flags.mirroring      = ines[6][0] ^ invert_mirroring;
		mapper_flags.chr_size       = size_code(ines[5]);
		mapper_flags.prg_size       = size_code(ines[4]);
		mapper_flags.mapper         = {is_dirty ? 4'h0 : ines[7][7:4], ines[6][7:4]};
	end

	// Sequencer stops forwarding header bytes once the header is complete
	a_no_header_overrun: assert property (@(posedge clk) disable iff (reset_nes)
		header_full |-> !header_wr)
		else $error("header byte offered after 16 header bytes");

endmodule

//--- src/rom_load_sequencer.sv
////////////////////////////////////////////////////////////
// Load FSM for an iNES image
// Byte and address counters, write requests, busy/done/error
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rom_load_sequencer (
	input  logic                    clk,
	input  logic                    reset_nes,
	input  logic                    byte_valid,
	input  loader_pkg::byte_t       byte_data,
	input  logic                    write_busy,
	input  logic                    header_ok,
	input  loader_pkg::byte_count_t prg_bytes,
	input  loader_pkg::byte_count_t chr_bytes,
	output logic                    header_wr,
	output loader_pkg::byte_t       header_byte,
	output logic                    write_req,
	output loader_pkg::mem_write_t  write_cmd,
	output logic                    busy,
	output logic                    done,
	output logic                    error
);
	import loader_pkg::*;

	load_state_t state;
	byte_count_t bytes_left;   // Header, PRG or CHR bytes still to come
	mem_addr_t   mem_addr;     // Next write address
	logic        byte_take;    // Byte accepted this cycle
	logic        rom_active;

	// A byte is taken whenever no write is in flight
	assign byte_take  = byte_valid && !write_busy;
	assign rom_active = (state == LOAD_PRG || state == LOAD_CHR) && (bytes_left != '0);

	assign header_wr   = byte_take && (state == LOAD_HEADER);
	assign header_byte = byte_data;

	assign write_req      = byte_take && rom_active;
	assign write_cmd.addr = mem_addr;
	assign write_cmd.data = byte_data;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state      <= LOAD_HEADER;
			bytes_left <= byte_count_t'(HEADER_BYTES);
			mem_addr   <= PRG_BASE;
			busy       <= 1'b0;
			done       <= 1'b0;
			error      <= 1'b0;
		end else begin
			case (state)
				LOAD_HEADER: begin
					if (header_wr) begin
						bytes_left <= bytes_left - byte_count_t'(1);
						// Last header byte with signature and sizes already stored
						if (bytes_left == byte_count_t'(1)) begin
							busy       <= 1'b1;
							mem_addr   <= PRG_BASE;
							bytes_left <= prg_bytes;
							state      <= header_ok ? LOAD_PRG : LOAD_ERROR;
						end
					end
				end

				LOAD_PRG, LOAD_CHR: begin
					if (bytes_left != '0) begin
						if (write_req) begin
							bytes_left <= bytes_left - byte_count_t'(1);
							mem_addr   <= mem_addr + mem_addr_t'(1);
						end
					end else if (state == LOAD_PRG) begin
						state      <= LOAD_CHR;
						mem_addr   <= CHR_BASE;
						bytes_left <= chr_bytes;   // Zero for CHR RAM carts
					end else if (!write_busy) begin
						// Last CHR write acknowledged
						state <= LOAD_DONE;
						done  <= 1'b1;
						busy  <= 1'b0;
					end
				end

				LOAD_ERROR: begin
					error <= 1'b1;
					done  <= 1'b1;
					busy  <= 1'b0;
				end

				default: begin
					// LOAD_DONE swallows later bytes
					done <= 1'b1;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Writer holds only one command and stalls the source
	a_one_write_in_flight: assert property (@(posedge clk) disable iff (reset_nes)
		write_req |=> write_busy)
		else $error("writer did not take the write request");

	// Bytes after done are accepted and dropped
	a_no_write_after_done: assert property (@(posedge clk) disable iff (reset_nes)
		done |-> !write_req)
		else $error("write request after done");

endmodule

//--- src/wb_mem_writer.sv
////////////////////////////////////////////////////////////
// Wishbone classic write master, one command buffer
// Holds the cycle until ack and stalls the byte source
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module wb_mem_writer (
	input  logic                   clk,
	input  logic                   reset_nes,
	input  logic                   write_req,
	input  loader_pkg::mem_write_t write_cmd,
	output logic                   write_busy,
	output logic                   wb_cyc,
	output logic                   wb_stb,
	output logic                   wb_we,
	output loader_pkg::mem_addr_t  wb_adr,
	output loader_pkg::byte_t      wb_dat_o,
	input  logic                   wb_ack
);
	import loader_pkg::*;

	mem_write_t cmd_q;  // Write being presented on the bus

	// Bus control
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we  <= 1'b0;
		end else if (write_req) begin
			wb_cyc <= 1'b1;
			wb_stb <= 1'b1;
			wb_we  <= 1'b1;
		end else if (wb_stb && wb_ack) begin
			wb_cyc <= 1'b0;  // Single write, end of cycle
			wb_stb <= 1'b0;
			wb_we  <= 1'b0;
		end
	end

	// Command latched on the request cycle
	always_ff @(posedge clk) begin
		if (write_req)
			cmd_q <= write_cmd;
	end

	assign wb_adr   = cmd_q.addr;
	assign wb_dat_o = cmd_q.data;

	// Upstream wait, high until the ack edge
	assign write_busy = wb_cyc;

	a_adr_stable: assert property (@(posedge clk) disable iff (reset_nes)
		wb_stb && !wb_ack |=> $stable(wb_adr))
		else $error("address changed before ack");

	// Slave acks only a live strobe
	a_ack_in_cycle: assert property (@(posedge clk) disable iff (reset_nes)
		wb_ack |-> wb_cyc && wb_stb)
		else $error("ack outside a bus cycle");

endmodule

//--- src/nes_game_loader.sv
////////////////////////////////////////////////////////////
// NES cartridge image loader, top level
// Header decode, load sequencer and Wishbone write stage
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module nes_game_loader (
	input  logic                      clk,
	input  logic                      reset_nes,
	// Byte source
	input  logic                      byte_valid,
	input  loader_pkg::byte_t         byte_data,
	output logic                      byte_wait,
	// Cartridge memory
	output logic                      wb_cyc,
	output logic                      wb_stb,
	output logic                      wb_we,
	output loader_pkg::mem_addr_t     wb_adr,
	output loader_pkg::byte_t         wb_dat_o,
	input  logic                      wb_ack,
	// Control and status
	input  logic                      invert_mirroring,
	output loader_pkg::mapper_flags_t mapper_flags,
	output logic                      busy,
	output logic                      done,
	output logic                      error
);
	import loader_pkg::*;

	logic        header_wr;
	byte_t       header_byte;
	logic        header_ok;
	byte_count_t prg_bytes;
	byte_count_t chr_bytes;
	logic        write_req;
	mem_write_t  write_cmd;
	logic        write_busy;

	assign byte_wait = write_busy;  // Source waits while a write is pending

	ines_header_decode ines_header_decode_i (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.header_wr        (header_wr),
		.header_byte      (header_byte),
		.invert_mirroring (invert_mirroring),
		.header_ok        (header_ok),
		.prg_bytes        (prg_bytes),
		.chr_bytes        (chr_bytes),
		.mapper_flags     (mapper_flags)
	);

	rom_load_sequencer rom_load_sequencer_i (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.byte_valid  (byte_valid),
		.byte_data   (byte_data),
		.write_busy  (write_busy),
		.header_ok   (header_ok),
		.prg_bytes   (prg_bytes),
		.chr_bytes   (chr_bytes),
		.header_wr   (header_wr),
		.header_byte (header_byte),
		.write_req   (write_req),
		.write_cmd   (write_cmd),
		.busy        (busy),
		.done        (done),
		.error       (error)
	);

	wb_mem_writer wb_mem_writer_i (
		.clk        (clk),
		.reset_nes  (reset_nes),
		.write_req  (write_req),
		.write_cmd  (write_cmd),
		.write_busy (write_busy),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_o   (wb_dat_o),
		.wb_ack     (wb_ack)
	);

endmodule

//--- test/tb_loader_model.svh
////////////////////////////////////////////////////////////
// Reference model for the loader testbench
// Header builder, expected flags word, expected write address
////////////////////////////////////////////////////////////

`ifndef TB_LOADER_MODEL_SVH
`define TB_LOADER_MODEL_SVH

typedef byte_t [HEADER_BYTES-1:0] header_t;  // Index 0 is file byte 0

// Clean iNES 1.0 header, tail bytes zero
function automatic header_t make_header(input byte_t prg_pages, input byte_t chr_pages,
		input byte_t flags6, input byte_t flags7);
	header_t h;
	h    = '0;
	h[0] = INES_MAGIC[31:24];
	h[1] = INES_MAGIC[23:16];
	h[2] = INES_MAGIC[15:8];
	h[3] = INES_MAGIC[7:0];
	h[4] = prg_pages;
	h[5] = chr_pages;
	h[6] = flags6;
	h[7] = flags7;
	return h;
endfunction

// Smallest n with 2**n pages covering the count
function automatic size_code_t pages_to_code(input byte_t pages);
	size_code_t code;
	code = 3'd7;  // More than 64 pages
	for (int n = 6; n >= 0; n--) begin
		if (int'(pages) <= (1 << n))
			code = size_code_t'(n);
	end
	return code;
endfunction

function automatic mapper_flags_t expected_flags(input header_t h, input logic invert);
	mapper_flags_t f;
	logic          nes20;
	logic          junk;
	nes20 = (h[7][3:2] == 2'b10);
	junk  = (h[9][7:1] != 7'd0);
	for (int i = 10; i < HEADER_BYTES; i++) begin
		if (h[i[3:0]] != 8'd0)
			junk = 1'b1;
	end
	f                = '0;
	f.piano          = nes20 && (h[15][5:0] == PIANO_EXPANSION_ID);
	f.prg_ram_shift  = nes20 ? h[10][3:0] : 4'h0;
	f.has_saves      = h[6][1];
	f.submapper_byte = nes20 ? h[8] : 8'h00;
	f.four_screen    = h[6][3];
	f.chr_ram        = (h[5] == 8'd0);
	f.mirroring      = h[6][0] ^ invert;
	f.chr_size       = pages_to_code(h[5]);
	f.prg_size       = pages_to_code(h[4]);
	f.mapper         = {(junk && !nes20) ? 4'h0 : h[7][7:4], h[6][7:4]};  // Dirty tail
	return f;
endfunction

// PRG bytes first, then CHR from its own base
function automatic mem_addr_t expected_addr(input int unsigned index, input byte_count_t prg_len);
	mem_addr_t addr;
	if (index < 32'(prg_len))
		addr = PRG_BASE + mem_addr_t'(index);
	else
		addr = CHR_BASE + mem_addr_t'(index - 32'(prg_len));
	return addr;
endfunction

`endif

//--- test/tb_nes_game_loader.sv
////////////////////////////////////////////////////////////
// Testbench for the NES image loader
// Byte source, Wishbone memory model, write checker, report
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_nes_game_loader;
	import loader_pkg::*;

	`include "tb_loader_model.svh"

	localparam int PRG_PAGE    = 1 << PRG_PAGE_SHIFT;
	localparam int CHR_PAGE    = 1 << CHR_PAGE_SHIFT;
	localparam int EXTRA_BYTES = 4;  // Sent after a rejected header
	// Eight loads, seven PRG pages and two CHR pages over all tests
	localparam int TOTAL_BYTES = 8 * HEADER_BYTES + 2 * EXTRA_BYTES
		+ 7 * PRG_PAGE + 2 * CHR_PAGE;
	localparam int CYCLE_LIMIT = 6 * TOTAL_BYTES + 1000;

	logic          clk;
	logic          reset_nes;
	logic          byte_valid;
	byte_t         byte_data;
	logic          byte_wait;
	logic          wb_cyc;
	logic          wb_stb;
	logic          wb_we;
	mem_addr_t     wb_adr;
	byte_t         wb_dat_o;
	logic          wb_ack;
	logic          invert_mirroring;
	mapper_flags_t mapper_flags;
	logic          busy;
	logic          done;
	logic          error;

	integer        seed;
	string         cur_test;
	byte_t         image_q[$];     // PRG then CHR bytes of the image
	mem_write_t    captured_q[$];  // Writes acked by the memory model
	byte_count_t   exp_prg_len;
	int unsigned   exp_writes;
	int unsigned   write_count;
	int unsigned   chr_writes;
	int unsigned   test_errors;
	int unsigned   error_count;
	int unsigned   tests_run;
	int unsigned   tests_bad;
	int            cycle_count;

	nes_game_loader nes_game_loader_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Reporting and stimulus
	////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("** Error [%s] %s: expected %h, actual %h", cur_test, what, expected, actual);
		test_errors++;
		error_count++;
	endtask

	task automatic report_problem(input string what);
		$display("[%s] %s", cur_test, what);
		test_errors++;
		error_count++;
	endtask

	// Entered 1 ns after an edge, left 1 ns after the edge that takes the byte
	task automatic send_byte(input byte_t value);
		byte_valid = 1'b1;
		byte_data  = value;
		while (byte_wait) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic apply_reset();
		reset_nes  = 1'b1;
		byte_valid = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		reset_nes = 1'b0;
	endtask

	task automatic load_image(input string name, input header_t h, input logic inv,
			input logic bad_header, output mapper_flags_t flags_seen);
		byte_count_t   chr_len;
		mapper_flags_t want;
		int unsigned   total;
		cur_test    = name;
		test_errors = 0;
		write_count = 0;
		chr_writes  = 0;
		image_q.delete();
		captured_q.delete();
		exp_prg_len = bad_header ? '0 : byte_count_t'(h[4]) << PRG_PAGE_SHIFT;
		chr_len     = bad_header ? '0 : byte_count_t'(h[5]) << CHR_PAGE_SHIFT;
		exp_writes  = 32'(exp_prg_len) + 32'(chr_len);
		total       = bad_header ? 32'(EXTRA_BYTES) : exp_writes;
		for (int unsigned i = 0; i < total; i++)
			image_q.push_back(byte_t'($random(seed)));
		invert_mirroring = inv;
		apply_reset();
		if ({busy, done, error, wb_cyc} !== 4'b0000)
			report_problem("status or bus not idle after reset");
		for (int i = 0; i < HEADER_BYTES; i++)
			send_byte(h[i[3:0]]);
		if (!bad_header && busy !== 1'b1)
			report_problem("busy did not rise after the last header byte");
		foreach (image_q[i])
			send_byte(image_q[i]);
		byte_valid = 1'b0;
		while (done !== 1'b1) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#3;  // Checker has drained the capture queue
		if (error !== bad_header)
			report_mismatch("error", 32'(bad_header), 32'(error));
		if (busy !== 1'b0)
			report_mismatch("busy", 32'd0, 32'(busy));
		if (write_count != exp_writes)
			report_mismatch("write count", exp_writes, write_count);
		if (chr_writes != 32'(chr_len))
			report_mismatch("CHR region writes", 32'(chr_len), chr_writes);
		want = expected_flags(h, inv);
		if (!bad_header && mapper_flags !== want)
			report_mismatch("mapper flags", want, mapper_flags);
		flags_seen = mapper_flags;
	endtask

	task automatic finish_test();
		$display("%-16s %0d writes, %0d errors", cur_test, write_count, test_errors);
		tests_run++;
		if (test_errors != 0)
			tests_bad++;
	endtask

	////////////////////////////////////////////////////////////
	// Memory model and write checker
	////////////////////////////////////////////////////////////

	initial begin : memory_model
		int         ack_delay;
		logic       armed;
		mem_write_t seen;
		wb_ack    = 1'b0;
		armed     = 1'b0;
		ack_delay = 0;
		forever begin
			@(posedge clk);
			#1;
			if (wb_ack) begin
				wb_ack = 1'b0;  // One cycle ack
			end else if (wb_cyc && wb_stb && wb_we) begin
				if (!armed) begin
					ack_delay = $random(seed) & 3;
					armed     = 1'b1;
				end
				if (ack_delay == 0) begin
					seen.addr = wb_adr;
					seen.data = wb_dat_o;
					captured_q.push_back(seen);
					wb_ack = 1'b1;
					armed  = 1'b0;
				end else begin
					ack_delay--;
				end
			end
		end
	end

	initial begin : compare_writes
		mem_write_t got;
		mem_addr_t  want_addr;
		forever begin
			@(posedge clk);
			#2;
			while (captured_q.size() > 0) begin
				got = captured_q.pop_front();
				if (write_count >= exp_writes) begin
					report_problem($sformatf("unexpected write at address %h", got.addr));
				end else begin
					want_addr = expected_addr(write_count, exp_prg_len);
					if (got.addr !== want_addr)
						report_mismatch("write address", 32'(want_addr), 32'(got.addr));
					if (got.data !== image_q[write_count])
						report_mismatch("write data", 32'(image_q[write_count]), 32'(got.data));
				end
				if (got.addr >= CHR_BASE)
					chr_writes++;
				write_count++;
			end
		end
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout, no result after %0d clock cycles", CYCLE_LIMIT);
		$display("Test failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin : run_tests
		header_t       h;
		mapper_flags_t flags_a;
		mapper_flags_t flags_b;
		mapper_flags_t mirror_only;
		seed             = 32'h80ea_8496;
		error_count      = 0;
		tests_run        = 0;
		tests_bad        = 0;
		exp_writes       = 0;
		reset_nes        = 1'b1;
		byte_valid       = 1'b0;
		byte_data        = '0;
		invert_mirroring = 1'b0;
		@(posedge clk);
		#1;

		load_image("ines_prg1_chr1", make_header(8'd1, 8'd1, 8'h31, 8'h00), 1'b0, 1'b0, flags_a);
		finish_test();

		// CHR RAM cart, nothing goes to the CHR region
		load_image("chr_ram_prg2", make_header(8'd2, 8'd0, 8'h10, 8'h00), 1'b0, 1'b0, flags_a);
		if (flags_a.chr_ram !== 1'b1)
			report_mismatch("chr_ram", 32'd1, 32'(flags_a.chr_ram));
		finish_test();

		h    = make_header(8'd1, 8'd1, 8'h00, 8'h00);
		h[3] = 8'h1B;  // Broken signature
		load_image("bad_signature", h, 1'b0, 1'b1, flags_a);
		finish_test();

		load_image("trainer_set", make_header(8'd1, 8'd1, 8'h04, 8'h00), 1'b0, 1'b1, flags_a);
		finish_test();

		// NES 2.0 with mapper 41h, submapper, PRG RAM shift and piano
		h     = make_header(8'd1, 8'd1, 8'h12, 8'h48);
		h[8]  = 8'h35;
		h[10] = 8'h07;
		h[15] = {2'b00, PIANO_EXPANSION_ID};
		load_image("nes20_flags", h, 1'b0, 1'b0, flags_a);
		if (flags_a.mapper !== 8'h41)
			report_mismatch("mapper", 32'h41, 32'(flags_a.mapper));
		if (flags_a.submapper_byte !== 8'h35)
			report_mismatch("submapper", 32'h35, 32'(flags_a.submapper_byte));
		if (flags_a.prg_ram_shift !== 4'h7)
			report_mismatch("prg_ram_shift", 32'h7, 32'(flags_a.prg_ram_shift));
		if (flags_a.piano !== 1'b1)
			report_mismatch("piano", 32'd1, 32'(flags_a.piano));
		finish_test();

		h     = make_header(8'd1, 8'd0, 8'h20, 8'h70);
		h[12] = 8'h44;  // Ripper tag in the tail
		h[13] = 8'h69;
		load_image("dirty_ines1", h, 1'b0, 1'b0, flags_a);
		if (flags_a.mapper !== 8'h02)
			report_mismatch("mapper", 32'h02, 32'(flags_a.mapper));
		finish_test();

		h = make_header(8'd1, 8'd0, 8'h01, 8'h00);
		load_image("mirroring_inv0", h, 1'b0, 1'b0, flags_a);
		finish_test();
		load_image("mirroring_inv1", h, 1'b1, 1'b0, flags_b);
		mirror_only           = '0;
		mirror_only.mirroring = 1'b1;
		if ((flags_a ^ flags_b) !== mirror_only)
			report_mismatch("flag change from inversion", mirror_only, flags_a ^ flags_b);
		finish_test();

		$display("%0d tests, %0d with errors, %0d checks in error",
			tests_run, tests_bad, error_count);
		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- nes_loader.f
+incdir+test
src/loader_pkg.sv
src/ines_header_decode.sv
src/rom_load_sequencer.sv
src/wb_mem_writer.sv
src/nes_game_loader.sv
test/tb_nes_game_loader.sv

//--- run.sh
#!/bin/sh
# Build and run the NES loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_nes_game_loader \
	--Mdir "$BUILD_DIR" \
	-f nes_loader.f
if [ $? -ne 0 ]; then
	echo "Verilator build did not complete"
	exit 1
fi

"./$BUILD_DIR/Vtb_nes_game_loader" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Test passed" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
